// ==== design/floo_out_pkg.sv ====
// Route counts, lane width, flit header, payload union and flit type of the output stage
`default_nettype none

package floo_out_pkg;

  // Ordinary router inputs, the only ones that may join a reduction group
  localparam int unsigned NumRoutes = 4;
  // Merge-only inputs stacked above the ordinary ones, always unicast
  localparam int unsigned NumSlaveRoutes = 1;
  // All inputs competing for the output link
  localparam int unsigned NumInRoutes = NumRoutes + NumSlaveRoutes;
  // One reduction operand lane, two lanes fill a payload word
  localparam int unsigned LaneWidth = 16;

  // Kind of traffic carried by a flit
  typedef enum logic {
    Unicast           = 1'b0,
    ParallelReduction = 1'b1
  } commtype_e;

  // Lane-wise combine operation of a reduction group
  typedef enum logic {
    RedAdd = 1'b0,
    RedMax = 1'b1
  } red_op_e;

  // Mesh destination, two bits per axis
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } xy_id_t;

  // 11-bit flit header
  typedef struct packed {
    commtype_e            commtype;
    // Only meaningful for reductions
    red_op_e              red_op;
    // Ordinary routes that contribute to the group
    logic [NumRoutes-1:0] red_mask;
    // Tail of a wormhole packet
    logic                 last;
    xy_id_t               dst_id;
  } hdr_t;

  // Two reduction operands, high lane in the upper half of the word
  typedef struct packed {
    logic [LaneWidth-1:0] lane_hi;
    logic [LaneWidth-1:0] lane_lo;
  } red_lanes_t;

  // Same 32-bit word, plain data for unicast, two lanes for reductions
  typedef union packed {
    logic [2*LaneWidth-1:0] raw;
    red_lanes_t             lanes;
  } payload_u;

  // Header in the upper bits, payload below
  typedef struct packed {
    hdr_t     hdr;
    payload_u payload;
  } flit_t;

  // Width of one flit on the flat top-level ports
  localparam int unsigned FlitWidth = $bits(flit_t);

endpackage

`default_nettype wire

// ==== design/floo_wormhole_arbiter.sv ====
// Round-robin unicast arbiter that keeps its grant on a route until the packet tail leaves
`timescale 1ns/10ps
`default_nettype none

module floo_wormhole_arbiter import floo_out_pkg::*; #(
  parameter int unsigned NumInp = 5
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [NumInp-1:0]  valid_i,
  output logic [NumInp-1:0]  ready_o,
  input  flit_t [NumInp-1:0] data_i,
  output logic               valid_o,
  input  logic               ready_i,
  output flit_t              data_o
);

  // Set while a packet owns the output
  logic              lock_q;
  // One-hot route that owns the output while locked
  logic [NumInp-1:0] lock_gnt_q;
  // Thermometer of routes at or after the round-robin pointer
  logic [NumInp-1:0] prio_q;
  logic [NumInp-1:0] prio_next;
  logic [NumInp-1:0] gnt;
  logic [NumInp-1:0] gnt_shl;

  // One-hot lowest set bit of a request vector
  function automatic logic [NumInp-1:0] first_one(input logic [NumInp-1:0] req);
    logic [NumInp-1:0] oh;
    logic              found;
    oh    = '0;
    found = 1'b0;
    for (int i = 0; i < NumInp; i++) begin
      if (req[i] && !found) begin
        oh[i] = 1'b1;
        found = 1'b1;
      end
    end
    return oh;
  endfunction

  // Locked route first, else first request at or after the pointer, else wrap around
  always_comb begin
    if (lock_q) begin
      gnt = lock_gnt_q;
    end else if (|(valid_i & prio_q)) begin
      gnt = first_one(valid_i & prio_q);
    end else begin
      gnt = first_one(valid_i);
    end
  end

  // Output mux that gives all zeros when nothing is granted
  always_comb begin
    data_o = '0;
    for (int i = 0; i < NumInp; i++) begin
      if (gnt[i]) begin
        data_o = data_i[i];
      end
    end
  end

  assign valid_o = |(valid_i & gnt);
  assign ready_o = gnt & {NumInp{ready_i}};

  // Routes strictly above the winner and none when the top route won
  assign gnt_shl   = gnt << 1;
  assign prio_next = ~(gnt_shl - NumInp'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q     <= 1'b0;
      lock_gnt_q <= '0;
      prio_q     <= '1;
    end else if (valid_o) begin
      // A shown flit keeps its route until a tail is accepted
      // Also covers a stalled head so the output stays stable
      lock_q     <= !(ready_i && data_o.hdr.last);
      lock_gnt_q <= gnt;
      if (ready_i && data_o.hdr.last) begin
        prio_q <= prio_next;
      end
    end
  end

  // A stalled flit stays on the output until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("wormhole output changed while stalled");

endmodule

`default_nettype wire

// ==== design/floo_reduction_arbiter.sv ====
// Combinational collector that joins a complete reduction group into one flit
`timescale 1ns/10ps
`default_nettype none

module floo_reduction_arbiter import floo_out_pkg::*; (
  input  logic [NumRoutes-1:0]  valid_i,
  output logic [NumRoutes-1:0]  ready_o,
  input  flit_t [NumRoutes-1:0] data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output flit_t                 data_o
);

  // Lowest valid route, it decides the group
  logic [NumRoutes-1:0] ldr_oh;
  flit_t                ldr_flit;
  logic [NumRoutes-1:0] grp_mask;
  logic                 grp_complete;
  // Running lane result over the group
  red_lanes_t           acc;

  // One lane step, wrapping add or unsigned max
  function automatic logic [LaneWidth-1:0] lane_op(
    input red_op_e              op,
    input logic [LaneWidth-1:0] a,
    input logic [LaneWidth-1:0] b
  );
    if (op == RedMax) begin
      return (a > b) ? a : b;
    end
    return a + b;
  endfunction

  // Scan downwards so the lowest valid route ends up as leader
  always_comb begin
    ldr_oh   = '0;
    ldr_flit = '0;
    for (int i = NumRoutes - 1; i >= 0; i--) begin
      if (valid_i[i]) begin
        ldr_oh    = '0;
        ldr_oh[i] = 1'b1;
        ldr_flit  = data_i[i];
      end
    end
  end

  assign grp_mask = ldr_flit.hdr.red_mask;

  // Leader must be a member, and every member must be present
  assign grp_complete = |(ldr_oh & grp_mask) && ((valid_i & grp_mask) == grp_mask);

  // Start from the leader lanes and fold in the other members
  always_comb begin
    acc = ldr_flit.payload.lanes;
    for (int i = 0; i < NumRoutes; i++) begin
      if (grp_mask[i] && !ldr_oh[i]) begin
        acc.lane_hi = lane_op(ldr_flit.hdr.red_op, acc.lane_hi,
                              data_i[i].payload.lanes.lane_hi);
        acc.lane_lo = lane_op(ldr_flit.hdr.red_op, acc.lane_lo,
                              data_i[i].payload.lanes.lane_lo);
      end
    end
  end

  // Leader header, single flit so always a tail
  always_comb begin
    data_o               = ldr_flit;
    data_o.hdr.last      = 1'b1;
    data_o.payload.lanes = acc;
  end

  assign valid_o = grp_complete;

  // All members leave together, partial groups stay put
  assign ready_o = grp_complete ? (grp_mask & {NumRoutes{ready_i}}) : '0;

  // Members must agree with the leader on operation and membership
  always_comb begin
    for (int i = 0; i < NumRoutes; i++) begin
      if (valid_i[i] && grp_mask[i]) begin
        assert final (data_i[i].hdr.red_op == ldr_flit.hdr.red_op &&
                      data_i[i].hdr.red_mask == grp_mask)
          else $error("reduction member disagrees with leader header");
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/floo_prio_merge.sv ====
// Two-input fixed-priority stream merge that holds its pick while stalled
`timescale 1ns/10ps
`default_nettype none

module floo_prio_merge import floo_out_pkg::*; (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic [1:0]    valid_i,
  output logic [1:0]    ready_o,
  input  flit_t [1:0]   data_i,
  output logic          valid_o,
  input  logic          ready_i,
  output flit_t         data_o
);

  // Set after a stalled cycle, sel_q then overrides priority
  logic hold_q;
  logic sel_q;
  logic sel;

  // Input 0 wins whenever valid unless a stalled pick is held
  assign sel = hold_q ? sel_q : !valid_i[0];

  assign valid_o = valid_i[sel];
  assign data_o  = data_i[sel];
  assign ready_o = {sel, !sel} & {2{ready_i}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hold_q <= 1'b0;
      sel_q  <= 1'b0;
    end else begin
      hold_q <= valid_o && !ready_i;
      sel_q  <= sel;
    end
  end

  // Upstream holds its flit and the pick is held, so the output does not move
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("stalled merge output changed");

endmodule

`default_nettype wire

// ==== design/floo_output_arbiter.sv ====
// Output port top level, splits unicast and reduction traffic and merges the two results
`timescale 1ns/10ps
`default_nettype none

module floo_output_arbiter import floo_out_pkg::*; (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [NumInRoutes-1:0]           valid_i,
  output logic [NumInRoutes-1:0]           ready_o,
  // Route 0 in the low bits
  input  logic [NumInRoutes*FlitWidth-1:0] data_i,
  output logic                             valid_o,
  input  logic                             ready_i,
  output logic [FlitWidth-1:0]             data_o
);

  flit_t [NumInRoutes-1:0] in_flit;
  flit_t                   out_flit;
  // Inputs currently carrying a reduction flit
  logic [NumInRoutes-1:0]  reduce_mask;
  logic [NumInRoutes-1:0]  unicast_valid_in;
  logic [NumInRoutes-1:0]  unicast_ready_out;
  logic [NumInRoutes-1:0]  reduce_ready_out;
  logic [NumRoutes-1:0]    red_valid_in;
  logic [NumRoutes-1:0]    red_ready_out;
  flit_t                   unicast_flit;
  flit_t                   reduce_flit;
  logic                    unicast_valid_out;
  logic                    unicast_ready_in;
  logic                    reduce_valid_out;
  logic                    reduce_ready_in;

  assign in_flit = data_i;
  assign data_o  = out_flit;

  // Merge-only routes are never reduced
  for (genvar i = 0; i < NumInRoutes; i++) begin : gen_reduce_mask
    if (i < NumRoutes) begin : gen_full
      assign reduce_mask[i] = (in_flit[i].hdr.commtype == ParallelReduction);
    end else begin : gen_slave
      assign reduce_mask[i] = 1'b0;
    end
  end

  assign unicast_valid_in = valid_i & ~reduce_mask;
  assign red_valid_in     = valid_i[NumRoutes-1:0] & reduce_mask[NumRoutes-1:0];

  floo_wormhole_arbiter #(
    .NumInp (NumInRoutes)
  ) i_wormhole_arbiter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (unicast_valid_in),
    .ready_o (unicast_ready_out),
    .data_i  (in_flit),
    .valid_o (unicast_valid_out),
    .ready_i (unicast_ready_in),
    .data_o  (unicast_flit)
  );

  floo_reduction_arbiter i_reduction_arbiter (
    .valid_i (red_valid_in),
    .ready_o (red_ready_out),
    .data_i  (in_flit[NumRoutes-1:0]),
    .valid_o (reduce_valid_out),
    .ready_i (reduce_ready_in),
    .data_o  (reduce_flit)
  );

  // Reduction on input 0 takes precedence
  floo_prio_merge i_prio_merge (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i ({unicast_valid_out, reduce_valid_out}),
    .ready_o ({unicast_ready_in, reduce_ready_in}),
    .data_i  ({unicast_flit, reduce_flit}),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (out_flit)
  );

  // Merge-only routes see no reduction ready
  assign reduce_ready_out = {{NumSlaveRoutes{1'b0}}, red_ready_out};

  // Readies follow the side the merge is serving so a held unicast keeps its own ready
  assign ready_o = reduce_ready_in ? reduce_ready_out : unicast_ready_out;

  // Every output transfer takes its flit from at least one input
  assert property (@(posedge clk_i) disable iff (reset_i) valid_o && ready_i |-> |ready_o)
    else $error("output transfer without any input ready");

endmodule

`default_nettype wire

// ==== dv/floo_output_checker.sv ====
// Scoreboard with per-route unicast queues, reduction reference function and compare process
`timescale 1ns/10ps
`default_nettype none

module floo_output_checker import floo_out_pkg::*; (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [NumInRoutes-1:0]           in_valid_i,
  input  logic [NumInRoutes-1:0]           in_ready_i,
  input  logic [NumInRoutes*FlitWidth-1:0] in_data_i,
  input  logic                             out_valid_i,
  input  logic                             out_ready_i,
  input  logic [FlitWidth-1:0]             out_data_i,
  output int                               err_cnt_o,
  output int                               check_cnt_o,
  output int                               pending_o
);

  flit_t [NumInRoutes-1:0] in_flit;
  flit_t                   out_flit;
  // Valid reduction flits on ordinary routes
  logic [NumInRoutes-1:0]  red_v;
  flit_t                   uc_q [NumInRoutes][$];
  logic                    prev_stall;
  flit_t                   prev_flit;
  // Open unicast packet on the output and its route
  logic                    in_pkt;
  int                      pkt_src;
  int                      err_cnt   = 0;
  int                      check_cnt = 0;
  int                      pending   = 0;

  assign in_flit     = in_data_i;
  assign out_flit    = out_data_i;
  assign err_cnt_o   = err_cnt;
  assign check_cnt_o = check_cnt;
  assign pending_o   = pending;

  always_comb begin
    for (int i = 0; i < NumInRoutes; i++) begin
      red_v[i] = in_valid_i[i] && i < NumRoutes &&
                 in_flit[i].hdr.commtype == ParallelReduction;
    end
  end

  // Lowest route with a reduction flit, -1 for none
  function automatic int leader_of(input logic [NumRoutes-1:0] v);
    int ldr;
    ldr = -1;
    for (int i = 0; i < NumRoutes; i++) begin
      if (v[i] && ldr < 0) begin
        ldr = i;
      end
    end
    return ldr;
  endfunction

  // Leader inside its own mask and all members present
  function automatic logic group_ready(input flit_t [NumRoutes-1:0] f,
                                       input logic [NumRoutes-1:0] v);
    int ldr;
    ldr = leader_of(v);
    if (ldr < 0) begin
      return 1'b0;
    end
    return f[ldr].hdr.red_mask[ldr] && ((v & f[ldr].hdr.red_mask) == f[ldr].hdr.red_mask);
  endfunction

  // Reference flit, leader header with last set, lanes folded over the mask
  function automatic flit_t expect_reduce(input flit_t [NumRoutes-1:0] f,
                                          input logic [NumRoutes-1:0] v);
    flit_t                e;
    logic [LaneWidth-1:0] hi;
    logic [LaneWidth-1:0] lo;
    int                   ldr;
    ldr = leader_of(v);
    e   = '0;
    if (ldr >= 0) begin
      e = f[ldr];
    end
    hi = '0;
    lo = '0;
    for (int i = 0; i < NumRoutes; i++) begin
      if (e.hdr.red_mask[i]) begin
        // 16-bit sums wrap on their own
        if (e.hdr.red_op == RedAdd) begin
          hi = hi + f[i].payload.lanes.lane_hi;
          lo = lo + f[i].payload.lanes.lane_lo;
        end else begin
          if (f[i].payload.lanes.lane_hi > hi) begin
            hi = f[i].payload.lanes.lane_hi;
          end
          if (f[i].payload.lanes.lane_lo > lo) begin
            lo = f[i].payload.lanes.lane_lo;
          end
        end
      end
    end
    e.hdr.last              = 1'b1;
    e.payload.lanes.lane_hi = hi;
    e.payload.lanes.lane_lo = lo;
    return e;
  endfunction

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  always @(posedge clk_i) begin : compare
    logic       red_taken;
    logic [3:0] src_bits;
    int         src;
    flit_t      exp_f;
    if (reset_i) begin
      prev_stall <= 1'b0;
      in_pkt     <= 1'b0;
      pkt_src    <= 0;
    end else begin
      red_taken = 1'b0;
      // Inputs first, a flit can leave in the cycle it arrives
      for (int i = 0; i < NumInRoutes; i++) begin
        if (in_valid_i[i] && in_ready_i[i]) begin
          if (red_v[i]) begin
            red_taken = 1'b1;
          end else begin
            uc_q[i].push_back(in_flit[i]);
            pending++;
          end
        end
      end
      if (prev_stall) begin
        if (!out_valid_i) begin
          report_error("output valid dropped during a stall");
        end else begin
          check_flit("stall_hold", prev_flit, out_flit);
        end
      end
      if (out_valid_i && !out_ready_i && in_ready_i != '0) begin
        report_error("an input ready was high while the output was stalled");
      end
      if (out_valid_i && out_ready_i) begin
        if (out_flit.hdr.commtype == ParallelReduction) begin
          exp_f = expect_reduce(in_flit[NumRoutes-1:0], red_v[NumRoutes-1:0]);
          check_flit("reduction", exp_f, out_flit);
          if (in_ready_i != NumInRoutes'(exp_f.hdr.red_mask)) begin
            report_error("input readies of a reduction transfer differ from the group mask");
          end
        end else begin
          src_bits = out_flit.hdr.dst_id;
          src      = int'(src_bits);
          if (src >= NumInRoutes || uc_q[src].size() == 0) begin
            report_error("unicast flit left without a matching accepted input flit");
          end else begin
            exp_f = uc_q[src].pop_front();
            pending--;
            check_flit("unicast_order", exp_f, out_flit);
          end
          if (in_pkt && src != pkt_src) begin
            report_error("unicast flit from another route cut into an open packet");
          end
          in_pkt  <= !out_flit.hdr.last;
          pkt_src <= src;
          // Only a unicast that was already stalled may pass a complete group
          if (group_ready(in_flit[NumRoutes-1:0], red_v[NumRoutes-1:0]) &&
              !(prev_stall && prev_flit == out_flit)) begin
            report_error("unicast flit passed a complete reduction group");
          end
        end
      end
      if (red_taken && !(out_valid_i && out_ready_i &&
                         out_flit.hdr.commtype == ParallelReduction)) begin
        report_error("reduction inputs were consumed without an output flit");
      end
      prev_stall <= out_valid_i && !out_ready_i;
      prev_flit  <= out_flit;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_floo_output_arbiter.sv ====
// Testbench top with clock, reset, LFSR route drivers, timeout and closing report
`timescale 1ns/10ps
`default_nettype none

module tb_floo_output_arbiter import floo_out_pkg::*; ();

  localparam int NumItems      = 600;
  localparam int MaxFlits      = 4;
  // Full-length items, half the cycles stalled, margin of four, plus reset
  localparam int TimeoutCycles = NumItems * MaxFlits * 2 * 4 + 800;

  logic                    clk     = 1'b0;
  logic                    reset   = 1'b1;
  logic [NumInRoutes-1:0]  valid_q = '0;
  flit_t [NumInRoutes-1:0] flit_q  = '0;
  logic                    ready_q = 1'b0;
  logic [NumInRoutes-1:0]  dut_ready;
  logic                    dut_valid;
  logic [FlitWidth-1:0]    dut_data;
  // Flits still to send after the one on the port
  int                      rem_q [NumInRoutes];
  logic [31:0]             lfsr_q  = 32'hc02a;
  int                      items   = 0;
  int                      cycles  = 0;
  int                      err_cnt;
  int                      check_cnt;
  int                      pending;

  floo_output_arbiter i_dut (
    .clk_i   (clk),
    .reset_i (reset),
    .valid_i (valid_q),
    .ready_o (dut_ready),
    .data_i  (flit_q),
    .valid_o (dut_valid),
    .ready_i (ready_q),
    .data_o  (dut_data)
  );

  floo_output_checker i_checker (
    .clk_i       (clk),
    .reset_i     (reset),
    .in_valid_i  (valid_q),
    .in_ready_i  (dut_ready),
    .in_data_i   (flit_q),
    .out_valid_i (dut_valid),
    .out_ready_i (ready_q),
    .out_data_i  (dut_data),
    .err_cnt_o   (err_cnt),
    .check_cnt_o (check_cnt),
    .pending_o   (pending)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Source route rides in dst_id so the checker can find its queue
  function automatic flit_t make_flit(input commtype_e ct, input red_op_e op,
                                      input logic [NumRoutes-1:0] mask, input logic last,
                                      input int src, input logic [31:0] word);
    flit_t f;
    f.hdr.commtype = ct;
    f.hdr.red_op   = op;
    f.hdr.red_mask = mask;
    f.hdr.last     = last;
    f.hdr.dst_id   = 4'(src);
    f.payload.raw  = word;
    return f;
  endfunction

  task automatic report_counts();
    $display("checks %0d errors %0d lost flits %0d", check_cnt, err_cnt, pending);
  endtask

  initial begin
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

  // All route drivers in one pass, groups claim idle routes before new packets
  always @(posedge clk) begin : drive
    logic [31:0]            r;
    logic [1:0]             len;
    logic [NumRoutes-1:0]   grp;
    logic [NumInRoutes-1:0] busy;
    logic                   red_busy;
    red_op_e                op;
    if (reset) begin
      valid_q <= '0;
      ready_q <= 1'b0;
    end else begin
      draw(1, r);
      ready_q  <= r[0];
      red_busy = 1'b0;
      grp      = '0;
      for (int i = 0; i < NumInRoutes; i++) begin
        if (valid_q[i] && flit_q[i].hdr.commtype == ParallelReduction) begin
          red_busy = 1'b1;
        end
        // Accepted, so show the next flit of the packet or go idle
        if (valid_q[i] && dut_ready[i]) begin
          if (rem_q[i] > 0) begin
            draw(32, r);
            flit_q[i] <= make_flit(Unicast, RedAdd, '0, rem_q[i] == 1, i, r);
            rem_q[i]  <= rem_q[i] - 1;
          end else begin
            valid_q[i] <= 1'b0;
          end
        end
      end
      // One group at a time, all members shown together
      draw(2, r);
      if (!red_busy && r[1:0] == 2'd0 && items < NumItems) begin
        draw(4, r);
        grp = r[3:0] & ~valid_q[NumRoutes-1:0];
        draw(1, r);
        op = red_op_e'(r[0]);
        for (int i = 0; i < NumRoutes; i++) begin
          if (grp[i]) begin
            draw(32, r);
            flit_q[i]  <= make_flit(ParallelReduction, op, grp, 1'b1, i, r);
            valid_q[i] <= 1'b1;
            rem_q[i]   <= 0;
          end
        end
        if (grp != '0) begin
          items++;
        end
      end
      busy = valid_q | NumInRoutes'(grp);
      // Unicast packets of one to four flits on routes still idle
      for (int i = 0; i < NumInRoutes; i++) begin
        draw(1, r);
        if (!busy[i] && r[0] && items < NumItems) begin
          draw(2, r);
          len = r[1:0];
          draw(32, r);
          flit_q[i]  <= make_flit(Unicast, RedAdd, '0, len == 2'd0, i, r);
          rem_q[i]   <= int'(len);
          valid_q[i] <= 1'b1;
          items++;
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, traffic stopped draining", cycles);
      report_counts();
      $display(">>> FAIL");
      $finish;
    end
  end

  // Done once every item is out of the drivers
  initial begin : finish_run
    @(negedge clk);
    while (reset || items < NumItems || valid_q != '0) begin
      @(negedge clk);
    end
    if (pending != 0) begin
      $display("Some accepted unicast flits never reached the output");
    end
    report_counts();
    if (err_cnt == 0 && pending == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/floo_out_pkg.sv
design/floo_wormhole_arbiter.sv
design/floo_reduction_arbiter.sv
design/floo_prio_merge.sv
design/floo_output_arbiter.sv
dv/floo_output_checker.sv
dv/tb_floo_output_arbiter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the output arbiter testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module tb_floo_output_arbiter \
  -o tb_floo_output_arbiter > build.log 2>&1 \
  && ./obj_dir/tb_floo_output_arbiter > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
